// File: common/nes_debug_pkg.sv
package nes_debug_pkg;

  // command bytes, first byte of every frame
  localparam logic [7:0] CMD_READ_MEM    = 8'h01;
  localparam logic [7:0] CMD_WRITE_MEM   = 8'h02;
  localparam logic [7:0] CMD_READ_VALUE  = 8'h03;
  localparam logic [7:0] CMD_WRITE_VALUE = 8'h04;

  // debug value ids
  // bit 0 set releases the NES from reset
  localparam logic [15:0] VALUE_ID_NES_RUN  = 16'd0;
  // bit 0 picks the pool for memory commands
  localparam logic [15:0] VALUE_ID_MEM_POOL = 16'd1;

  // memory pools
  localparam logic POOL_PRG = 1'b0;
  localparam logic POOL_RAM = 1'b1;

  // pool address width
  localparam int ADDR_W_DEFAULT = 10;

  // bus direction levels
  localparam logic RW_READ  = 1'b1;
  localparam logic RW_WRITE = 1'b0;

endpackage

// File: debugger/nes_debugger.sv
`timescale 1ns/1ps

module nes_debugger (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_spi_cs_n,
  input  logic        i_rx_dv,
  input  logic [7:0]  i_rx_byte,
  input  logic        i_pool_sel,
  input  logic        i_mem_dv_prg,
  input  logic [7:0]  i_mem_data_prg,
  input  logic        i_mem_dv_ram,
  input  logic [7:0]  i_mem_data_ram,
  input  logic [15:0] i_value_data,
  output logic        o_tx_dv,
  output logic [7:0]  o_tx_byte,
  output logic        o_mem_en_prg,
  output logic        o_mem_en_ram,
  output logic        o_mem_rw,
  output logic [15:0] o_mem_address,
  output logic [7:0]  o_mem_data,
  output logic        o_value_en,
  output logic        o_value_wea,
  output logic [15:0] o_value_id,
  output logic [15:0] o_value_data
);

  typedef enum logic [3:0] {
    S_CMD, S_ADDR_LO, S_ADDR_HI, S_CNT_LO, S_CNT_HI, S_MEM_READ, S_MEM_WRITE,
    S_ID_LO, S_ID_HI, S_DATA_LO, S_DATA_HI, S_VALUE_RESP, S_DONE
  } state_t;

  state_t      state;
  logic [7:0]  cmd;
  logic [15:0] count;
  logic [15:0] count_rx;
  logic        pool;
  logic        mem_en;
  logic        mem_dv;
  logic [7:0]  mem_rdata;
  logic        value_rd_wait;
  logic [7:0]  value_hi;
  logic [1:0]  cs_sync;

  // pool is latched with the command byte and steers the whole frame
  assign mem_dv       = (pool == nes_debug_pkg::POOL_RAM) ? i_mem_dv_ram : i_mem_dv_prg;
  assign mem_rdata    = (pool == nes_debug_pkg::POOL_RAM) ? i_mem_data_ram : i_mem_data_prg;
  assign o_mem_en_prg = mem_en & (pool == nes_debug_pkg::POOL_PRG);
  assign o_mem_en_ram = mem_en & (pool == nes_debug_pkg::POOL_RAM);
  assign count_rx     = {i_rx_byte, count[7:0]};

  always_ff @(posedge i_clk)
  begin
    cs_sync       <= {cs_sync[0], i_spi_cs_n};
    mem_en        <= 1'b0;
    o_tx_dv       <= 1'b0;
    o_value_en    <= 1'b0;
    // value read data shows up the cycle after en
    value_rd_wait <= o_value_en & ~o_value_wea;

    if (i_rst || cs_sync[1])
    begin
      // cs high ends the frame
      state         <= S_CMD;
      count         <= 16'd0;
      value_rd_wait <= 1'b0;
    end
    else
    begin
      if (mem_dv)
      begin
        o_mem_address <= o_mem_address + 16'd1;
        if (o_mem_rw == nes_debug_pkg::RW_READ)
        begin
          o_tx_dv   <= 1'b1;
          o_tx_byte <= mem_rdata;
        end
      end

      if (value_rd_wait)
      begin
        o_tx_dv   <= 1'b1;
        o_tx_byte <= i_value_data[7:0];
        value_hi  <= i_value_data[15:8];
      end

      if (i_rx_dv)
      begin
        case (state)
          S_CMD:
          begin
            cmd  <= i_rx_byte;
            pool <= i_pool_sel;
            if (i_rx_byte == nes_debug_pkg::CMD_READ_MEM ||
                i_rx_byte == nes_debug_pkg::CMD_WRITE_MEM)
              state <= S_ADDR_LO;
            else if (i_rx_byte == nes_debug_pkg::CMD_READ_VALUE ||
                     i_rx_byte == nes_debug_pkg::CMD_WRITE_VALUE)
              state <= S_ID_LO;
            else
              state <= S_DONE;
          end
          S_ADDR_LO:
          begin
            o_mem_address[7:0] <= i_rx_byte;
            state              <= S_ADDR_HI;
          end
          S_ADDR_HI:
          begin
            o_mem_address[15:8] <= i_rx_byte;
            state               <= S_CNT_LO;
          end
          S_CNT_LO:
          begin
            count[7:0] <= i_rx_byte;
            state      <= S_CNT_HI;
          end
          S_CNT_HI:
          begin
            if (count_rx == 16'd0)
            begin
              state <= S_DONE;
            end
            else if (cmd == nes_debug_pkg::CMD_READ_MEM)
            begin
              // first byte fetched now, ready for slot 5
              mem_en   <= 1'b1;
              o_mem_rw <= nes_debug_pkg::RW_READ;
              count    <= count_rx - 16'd1;
              state    <= S_MEM_READ;
            end
            else
            begin
              count <= count_rx;
              state <= S_MEM_WRITE;
            end
          end
          S_MEM_READ:
          begin
            if (count == 16'd0)
            begin
              state <= S_DONE;
            end
            else
            begin
              mem_en   <= 1'b1;
              o_mem_rw <= nes_debug_pkg::RW_READ;
              count    <= count - 16'd1;
            end
          end
          S_MEM_WRITE:
          begin
            mem_en     <= 1'b1;
            o_mem_rw   <= nes_debug_pkg::RW_WRITE;
            o_mem_data <= i_rx_byte;
            count      <= count - 16'd1;
            if (count == 16'd1)
              state <= S_DONE;
          end
          S_ID_LO:
          begin
            o_value_id[7:0] <= i_rx_byte;
            state           <= S_ID_HI;
          end
          S_ID_HI:
          begin
            o_value_id[15:8] <= i_rx_byte;
            if (cmd == nes_debug_pkg::CMD_READ_VALUE)
            begin
              o_value_en  <= 1'b1;
              o_value_wea <= 1'b0;
              state       <= S_VALUE_RESP;
            end
            else
            begin
              state <= S_DATA_LO;
            end
          end
          S_DATA_LO:
          begin
            o_value_data[7:0] <= i_rx_byte;
            state             <= S_DATA_HI;
          end
          S_DATA_HI:
          begin
            o_value_data[15:8] <= i_rx_byte;
            o_value_en         <= 1'b1;
            o_value_wea        <= 1'b1;
            state              <= S_DONE;
          end
          S_VALUE_RESP:
          begin
            // high byte goes out in slot 4
            o_tx_dv   <= 1'b1;
            o_tx_byte <= value_hi;
            state     <= S_DONE;
          end
          default:
          begin
            state <= S_DONE;
          end
        endcase
      end
    end
  end

endmodule

// File: flist.f
common/nes_debug_pkg.sv
spi/spi_peripheral.sv
debugger/nes_debugger.sv
hdl/debugger_values.sv
hdl/debugger_mcu.sv
hdl/pool_memory.sv
hdl/nes_debugger_top.sv
test/nes_debugger_props.sv
test/tb_nes_debugger_top.sv

// File: hdl/debugger_mcu.sv
`timescale 1ns/1ps

module debugger_mcu #(
  parameter int ADDR_W = 10
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_nes_en,
  input  logic              i_nes_rw,
  input  logic [15:0]       i_nes_address,
  input  logic [7:0]        i_nes_data,
  input  logic              i_dbg_en,
  input  logic              i_dbg_rw,
  input  logic [15:0]       i_dbg_address,
  input  logic [7:0]        i_dbg_data,
  input  logic [7:0]        i_mem_data,
  output logic [7:0]        o_nes_data,
  output logic              o_dbg_dv,
  output logic [7:0]        o_dbg_data,
  output logic              o_mem_en,
  output logic              o_mem_wea,
  output logic [ADDR_W-1:0] o_mem_address,
  output logic [7:0]        o_mem_data
);

  logic        pend_valid;
  logic        pend_rw;
  logic [15:0] pend_address;
  logic [7:0]  pend_data;

  logic        dbg_go;
  logic        dbg_rw;
  logic [15:0] dbg_address;
  logic [7:0]  dbg_data;

  logic        nes_rd_q;
  logic [7:0]  nes_data_q;

  // debugger only gets cycles where the NES is idle
  assign dbg_go      = (i_dbg_en | pend_valid) & ~i_nes_en;
  assign dbg_rw      = i_dbg_en ? i_dbg_rw : pend_rw;
  assign dbg_address = i_dbg_en ? i_dbg_address : pend_address;
  assign dbg_data    = i_dbg_en ? i_dbg_data : pend_data;

  assign o_mem_en      = i_nes_en | dbg_go;
  assign o_mem_wea     = i_nes_en ? (i_nes_rw == nes_debug_pkg::RW_WRITE)
                                  : (dbg_rw == nes_debug_pkg::RW_WRITE);
  assign o_mem_address = i_nes_en ? i_nes_address[ADDR_W-1:0] : dbg_address[ADDR_W-1:0];
  assign o_mem_data    = i_nes_en ? i_nes_data : dbg_data;

  // read data goes to whoever owned the previous cycle
  assign o_dbg_data = i_mem_data;
  assign o_nes_data = nes_rd_q ? i_mem_data : nes_data_q;

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      pend_valid <= 1'b0;
      o_dbg_dv   <= 1'b0;
      nes_rd_q   <= 1'b0;
    end
    else
    begin
      pend_valid <= (i_dbg_en | pend_valid) & i_nes_en;
      o_dbg_dv   <= dbg_go;
      nes_rd_q   <= i_nes_en & (i_nes_rw == nes_debug_pkg::RW_READ);
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_dbg_en)
    begin
      pend_rw      <= i_dbg_rw;
      pend_address <= i_dbg_address;
      pend_data    <= i_dbg_data;
    end
    // hold NES data once the memory moves on
    if (nes_rd_q)
      nes_data_q <= i_mem_data;
  end

endmodule

// File: hdl/debugger_values.sv
`timescale 1ns/1ps

module debugger_values (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_en,
  input  logic        i_wea,
  input  logic [15:0] i_id,
  input  logic [15:0] i_data,
  output logic [15:0] o_data,
  output logic        o_nes_reset_n,
  output logic        o_pool_sel
);

  logic run;
  logic pool;

  // NES stays in reset until the host sets the run bit
  assign o_nes_reset_n = run;
  assign o_pool_sel    = pool;

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      run    <= 1'b0;
      pool   <= nes_debug_pkg::POOL_PRG;
      o_data <= 16'h0000;
    end
    else if (i_en)
    begin
      if (i_wea)
      begin
        if (i_id == nes_debug_pkg::VALUE_ID_NES_RUN)
          run <= i_data[0];
        else if (i_id == nes_debug_pkg::VALUE_ID_MEM_POOL)
          pool <= i_data[0];
      end
      else
      begin
        // unknown ids read back as zero
        if (i_id == nes_debug_pkg::VALUE_ID_NES_RUN)
          o_data <= {15'd0, run};
        else if (i_id == nes_debug_pkg::VALUE_ID_MEM_POOL)
          o_data <= {15'd0, pool};
        else
          o_data <= 16'h0000;
      end
    end
  end

endmodule

// File: hdl/nes_debugger_top.sv
`timescale 1ns/1ps

module nes_debugger_top #(
  parameter int ADDR_W = nes_debug_pkg::ADDR_W_DEFAULT
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_spi_clk,
  input  logic        i_spi_cs_n,
  input  logic        i_spi_copi,
  output logic        o_spi_cipo,
  input  logic        i_prg_nes_en,
  input  logic [15:0] i_prg_nes_address,
  output logic [7:0]  o_prg_nes_data,
  input  logic        i_ram_nes_en,
  input  logic        i_ram_nes_rw,
  input  logic [15:0] i_ram_nes_address,
  input  logic [7:0]  i_ram_nes_data,
  output logic [7:0]  o_ram_nes_data,
  output logic        o_nes_reset_n
);

  logic              rx_dv;
  logic [7:0]        rx_byte;
  logic              tx_dv;
  logic [7:0]        tx_byte;

  logic              dbg_mem_en_prg;
  logic              dbg_mem_en_ram;
  logic              dbg_mem_rw;
  logic [15:0]       dbg_mem_address;
  logic [7:0]        dbg_mem_data;
  logic              dbg_dv_prg;
  logic [7:0]        dbg_data_prg;
  logic              dbg_dv_ram;
  logic [7:0]        dbg_data_ram;

  logic              value_en;
  logic              value_wea;
  logic [15:0]       value_id;
  logic [15:0]       value_data_wr;
  logic [15:0]       value_data_rd;
  logic              pool_sel;

  logic              mem_prg_en;
  logic              mem_prg_wea;
  logic [ADDR_W-1:0] mem_prg_address;
  logic [7:0]        mem_prg_data_wr;
  logic [7:0]        mem_prg_data_rd;

  logic              mem_ram_en;
  logic              mem_ram_wea;
  logic [ADDR_W-1:0] mem_ram_address;
  logic [7:0]        mem_ram_data_wr;
  logic [7:0]        mem_ram_data_rd;

  spi_peripheral u_spi (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_spi_clk  (i_spi_clk),
    .i_spi_cs_n (i_spi_cs_n),
    .i_spi_copi (i_spi_copi),
    .i_tx_dv    (tx_dv),
    .i_tx_byte  (tx_byte),
    .o_spi_cipo (o_spi_cipo),
    .o_rx_dv    (rx_dv),
    .o_rx_byte  (rx_byte)
  );

  nes_debugger u_debugger (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_spi_cs_n     (i_spi_cs_n),
    .i_rx_dv        (rx_dv),
    .i_rx_byte      (rx_byte),
    .i_pool_sel     (pool_sel),
    .i_mem_dv_prg   (dbg_dv_prg),
    .i_mem_data_prg (dbg_data_prg),
    .i_mem_dv_ram   (dbg_dv_ram),
    .i_mem_data_ram (dbg_data_ram),
    .i_value_data   (value_data_rd),
    .o_tx_dv        (tx_dv),
    .o_tx_byte      (tx_byte),
    .o_mem_en_prg   (dbg_mem_en_prg),
    .o_mem_en_ram   (dbg_mem_en_ram),
    .o_mem_rw       (dbg_mem_rw),
    .o_mem_address  (dbg_mem_address),
    .o_mem_data     (dbg_mem_data),
    .o_value_en     (value_en),
    .o_value_wea    (value_wea),
    .o_value_id     (value_id),
    .o_value_data   (value_data_wr)
  );

  debugger_values u_values (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_en          (value_en),
    .i_wea         (value_wea),
    .i_id          (value_id),
    .i_data        (value_data_wr),
    .o_data        (value_data_rd),
    .o_nes_reset_n (o_nes_reset_n),
    .o_pool_sel    (pool_sel)
  );

  // PRG is read-only from the NES side
  debugger_mcu #(.ADDR_W(ADDR_W)) u_mcu_prg (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_nes_en      (i_prg_nes_en),
    .i_nes_rw      (nes_debug_pkg::RW_READ),
    .i_nes_address (i_prg_nes_address),
    .i_nes_data    (8'h00),
    .i_dbg_en      (dbg_mem_en_prg),
    .i_dbg_rw      (dbg_mem_rw),
    .i_dbg_address (dbg_mem_address),
    .i_dbg_data    (dbg_mem_data),
    .i_mem_data    (mem_prg_data_rd),
    .o_nes_data    (o_prg_nes_data),
    .o_dbg_dv      (dbg_dv_prg),
    .o_dbg_data    (dbg_data_prg),
    .o_mem_en      (mem_prg_en),
    .o_mem_wea     (mem_prg_wea),
    .o_mem_address (mem_prg_address),
    .o_mem_data    (mem_prg_data_wr)
  );

  pool_memory #(.ADDR_W(ADDR_W)) u_mem_prg (
    .i_clk  (i_clk),
    .i_ena  (mem_prg_en),
    .i_wea  (mem_prg_wea),
    .i_addr (mem_prg_address),
    .i_data (mem_prg_data_wr),
    .o_data (mem_prg_data_rd)
  );

  debugger_mcu #(.ADDR_W(ADDR_W)) u_mcu_ram (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_nes_en      (i_ram_nes_en),
    .i_nes_rw      (i_ram_nes_rw),
    .i_nes_address (i_ram_nes_address),
    .i_nes_data    (i_ram_nes_data),
    .i_dbg_en      (dbg_mem_en_ram),
    .i_dbg_rw      (dbg_mem_rw),
    .i_dbg_address (dbg_mem_address),
    .i_dbg_data    (dbg_mem_data),
    .i_mem_data    (mem_ram_data_rd),
    .o_nes_data    (o_ram_nes_data),
    .o_dbg_dv      (dbg_dv_ram),
    .o_dbg_data    (dbg_data_ram),
    .o_mem_en      (mem_ram_en),
    .o_mem_wea     (mem_ram_wea),
    .o_mem_address (mem_ram_address),
    .o_mem_data    (mem_ram_data_wr)
  );

  pool_memory #(.ADDR_W(ADDR_W)) u_mem_ram (
    .i_clk  (i_clk),
    .i_ena  (mem_ram_en),
    .i_wea  (mem_ram_wea),
    .i_addr (mem_ram_address),
    .i_data (mem_ram_data_wr),
    .o_data (mem_ram_data_rd)
  );

endmodule

// File: hdl/pool_memory.sv
`timescale 1ns/1ps

module pool_memory #(
  parameter int ADDR_W = 10
) (
  input  logic              i_clk,
  input  logic              i_ena,
  input  logic              i_wea,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [7:0]        i_data,
  output logic [7:0]        o_data
);

  logic [7:0] mem [2**ADDR_W];

  // read-first, a write returns the old byte
  always_ff @(posedge i_clk)
  begin
    if (i_ena)
    begin
      o_data <= mem[i_addr];
      if (i_wea)
        mem[i_addr] <= i_data;
    end
  end

endmodule

// File: spi/spi_peripheral.sv
`timescale 1ns/1ps

module spi_peripheral (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_spi_clk,
  input  logic       i_spi_cs_n,
  input  logic       i_spi_copi,
  input  logic       i_tx_dv,
  input  logic [7:0] i_tx_byte,
  output logic       o_spi_cipo,
  output logic       o_rx_dv,
  output logic [7:0] o_rx_byte
);

  // two sync flops each, sck gets a third for edge detection
  logic [2:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;

  logic       cs_active;
  logic       sck_rise;
  logic       sck_fall;

  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [7:0] tx_buf;
  logic [7:0] tx_shift;

  assign cs_active = ~cs_sync[1];
  assign sck_rise  = cs_active & sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = cs_active & ~sck_sync[1] & sck_sync[2];

  // at a slot boundary the MSB comes straight from the buffer,
  // so a byte loaded late in the gap still goes out whole
  assign o_spi_cipo = cs_active & ((bit_cnt == 3'd0) ? tx_buf[7] : tx_shift[7]);

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      sck_sync  <= 3'b000;
      cs_sync   <= 2'b11;
      copi_sync <= 2'b00;
    end
    else
    begin
      sck_sync  <= {sck_sync[1:0], i_spi_clk};
      cs_sync   <= {cs_sync[0], i_spi_cs_n};
      copi_sync <= {copi_sync[0], i_spi_copi};
    end
  end

  // receive side, sample on rising sck
  always_ff @(posedge i_clk)
  begin
    o_rx_dv <= 1'b0;
    if (i_rst || !cs_active)
    begin
      bit_cnt <= 3'd0;
    end
    else if (sck_rise)
    begin
      rx_shift <= {rx_shift[5:0], copi_sync[1]};
      bit_cnt  <= bit_cnt + 3'd1;
      if (bit_cnt == 3'd7)
      begin
        o_rx_dv   <= 1'b1;
        o_rx_byte <= {rx_shift, copi_sync[1]};
      end
    end
  end

  // transmit side, shift on falling sck
  always_ff @(posedge i_clk)
  begin
    if (i_rst || !cs_active)
    begin
      tx_buf   <= 8'h00;
      tx_shift <= 8'h00;
    end
    else
    begin
      if (sck_rise && bit_cnt == 3'd0)
      begin
        // slot start, an empty buffer sends zeros
        tx_shift <= tx_buf;
        tx_buf   <= 8'h00;
      end
      else if (sck_fall)
      begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
      if (i_tx_dv)
        tx_buf <= i_tx_byte;
    end
  end

endmodule

// File: test/debug_trace.txt
// 01 n b.. = SPI frame of n bytes, 02 slot m e.. = expected CIPO bytes of last frame
// 03 pool addr_lo addr_hi data = NES read, 04 level = expected o_nes_reset_n, ff = end
04 00
01 05 03 00 00 00 00
02 03 02 00 00
01 05 03 01 00 00 00
02 03 02 00 00
01 05 04 00 00 01 00
04 01
01 05 03 00 00 00 00
02 03 02 01 00
01 05 04 01 00 01 00
01 05 03 01 00 00 00
02 03 02 01 00
01 05 04 07 00 ef be
01 05 03 07 00 00 00
02 03 02 00 00
01 15 02 f0 03 10 00 10 21 32 43 54 65 76 87 98 a9 ba cb dc ed fe 0f
01 15 01 f0 03 10 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 05 10 10 21 32 43 54 65 76 87 98 a9 ba cb dc ed fe 0f
03 01 f5 03 65
01 09 02 10 00 04 00 de ad be ef
01 09 01 10 00 04 00 00 00 00 00
02 05 04 de ad be ef
03 01 12 00 be
01 05 04 01 00 00 00
01 15 02 f0 03 10 00 f0 e1 d2 c3 b4 a5 96 87 78 69 5a 4b 3c 2d 1e 0f
01 15 01 f0 03 10 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 05 10 f0 e1 d2 c3 b4 a5 96 87 78 69 5a 4b 3c 2d 1e 0f
03 00 fa 03 5a
03 01 f0 03 10
01 05 04 01 00 01 00
01 15 02 00 01 10 00 01 02 04 08 10 20 40 80 fe fd fb f7 ef df bf 7f
01 15 01 00 01 10 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 05 10 01 02 04 08 10 20 40 80 fe fd fb f7 ef df bf 7f
01 0d 02 00 02 08 00 11 22 33 44 55 66 77 88
01 07 02 00 02 08 00 aa bb
01 0d 01 00 02 08 00 00 00 00 00 00 00 00 00
02 05 08 aa bb 33 44 55 66 77 88
03 01 03 02 44
ff

// File: test/nes_debugger_props.sv
`timescale 1ns/1ps

module nes_debugger_props #(
  parameter int ADDR_W = 10
) (
  input logic              i_clk,
  input logic              i_rst,
  input logic              i_nes_en,
  input logic [15:0]       i_nes_address,
  input logic              i_dbg_en,
  input logic              i_dbg_dv,
  input logic [ADDR_W-1:0] i_mem_address
);

  logic dbg_open;

  // a debugger request is open from its en until its dv
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      dbg_open <= 1'b0;
    else if (i_dbg_en)
      dbg_open <= 1'b1;
    else if (i_dbg_dv)
      dbg_open <= 1'b0;
  end

  // NES owns the address bus while enabled
  nes_address_follows: assert property (@(posedge i_clk) disable iff (i_rst)
    i_nes_en |-> (i_mem_address == i_nes_address[ADDR_W-1:0]))
    else $error("memory address differs from NES address during NES access");

  // dv answers an open request and never a cycle served to the NES
  dv_not_after_nes: assert property (@(posedge i_clk) disable iff (i_rst)
    i_dbg_dv |-> (dbg_open && !$past(i_nes_en)))
    else $error("debugger dv without an open request or after a NES cycle");

  // bounded wait, NES bursts are short
  dbg_request_done: assert property (@(posedge i_clk) disable iff (i_rst)
    i_dbg_en |-> ##[1:8] i_dbg_dv)
    else $error("debugger request not completed within 8 cycles");

endmodule

bind debugger_mcu nes_debugger_props #(.ADDR_W(ADDR_W)) u_props (
  .i_clk         (i_clk),
  .i_rst         (i_rst),
  .i_nes_en      (i_nes_en),
  .i_nes_address (i_nes_address),
  .i_dbg_en      (i_dbg_en),
  .i_dbg_dv      (o_dbg_dv),
  .i_mem_address (o_mem_address)
);

// File: test/tb_nes_debugger_top.sv
`timescale 1ns/1ps

module tb_nes_debugger_top;

  localparam int ADDR_W    = nes_debug_pkg::ADDR_W_DEFAULT;
  localparam int TRACE_LEN = 2048;

  logic        clk;
  logic        rst;
  logic        spi_clk;
  logic        spi_cs_n;
  logic        spi_copi;
  logic        spi_cipo;
  logic        prg_nes_en;
  logic [15:0] prg_nes_address;
  logic [7:0]  prg_nes_rdata;
  logic        ram_nes_en;
  logic        ram_nes_rw;
  logic [15:0] ram_nes_address;
  logic [7:0]  ram_nes_wdata;
  logic [7:0]  ram_nes_rdata;
  logic        nes_reset_n;

  logic [7:0]  trace [TRACE_LEN];
  logic [7:0]  frame_tx [64];
  logic [7:0]  frame_rx [64];

  // host-side view of both pools, only written bytes are known
  logic [7:0]  model [2][2**ADDR_W];
  bit          known [2][2**ADDR_W];
  logic        cur_pool;
  integer      seed;
  int          watchdog_cycles;

  nes_debugger_top #(.ADDR_W(ADDR_W)) u_dut (
    .i_clk             (clk),
    .i_rst             (rst),
    .i_spi_clk         (spi_clk),
    .i_spi_cs_n        (spi_cs_n),
    .i_spi_copi        (spi_copi),
    .o_spi_cipo        (spi_cipo),
    .i_prg_nes_en      (prg_nes_en),
    .i_prg_nes_address (prg_nes_address),
    .o_prg_nes_data    (prg_nes_rdata),
    .i_ram_nes_en      (ram_nes_en),
    .i_ram_nes_rw      (ram_nes_rw),
    .i_ram_nes_address (ram_nes_address),
    .i_ram_nes_data    (ram_nes_wdata),
    .o_ram_nes_data    (ram_nes_rdata),
    .o_nes_reset_n     (nes_reset_n)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic check_nes(input string name, input logic pool, input logic [15:0] addr,
                           input logic [7:0] got);
    logic [ADDR_W-1:0] a;
    a = addr[ADDR_W-1:0];
    if (known[pool][a])
      check_value(name, got, model[pool][a]);
  endtask

  // mode 0, MSB first, CIPO sampled as SCK rises
  task automatic transfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    int b;
    for (b = 7; b >= 0; b--)
    begin
      spi_clk  = 1'b0;
      spi_copi = tx[b];
      repeat (4) @(negedge clk);
      spi_clk = 1'b1;
      rx[b]   = spi_cipo;
      repeat (4) @(negedge clk);
    end
    spi_clk = 1'b0;
  endtask

  // idle gap between bytes with random NES read bursts on both buses
  task automatic nes_gap();
    int c;
    int ram_start;
    int ram_len;
    int prg_start;
    int prg_len;
    ram_start = {$random(seed)} % 4;
    ram_len   = 1 + {$random(seed)} % 3;
    prg_start = {$random(seed)} % 4;
    prg_len   = 1 + {$random(seed)} % 3;
    for (c = 0; c < 16; c++)
    begin
      // data of last cycle's access is valid now
      if (ram_nes_en)
        check_nes("o_ram_nes_data", nes_debug_pkg::POOL_RAM, ram_nes_address, ram_nes_rdata);
      if (prg_nes_en)
        check_nes("o_prg_nes_data", nes_debug_pkg::POOL_PRG, prg_nes_address, prg_nes_rdata);
      ram_nes_en      = (c >= ram_start) && (c < ram_start + ram_len);
      ram_nes_address = 16'h03f0 + 16'({$random(seed)} % 16);
      prg_nes_en      = (c >= prg_start) && (c < prg_start + prg_len);
      prg_nes_address = 16'h03f0 + 16'({$random(seed)} % 16);
      @(negedge clk);
    end
    ram_nes_en = 1'b0;
    prg_nes_en = 1'b0;
  endtask

  // track pool contents and pool select from the frame just sent
  task automatic update_model(input int n);
    logic [15:0] addr;
    logic [15:0] count;
    logic [15:0] a;
    int i;
    addr  = {frame_tx[2], frame_tx[1]};
    count = {frame_tx[4], frame_tx[3]};
    if (frame_tx[0] == nes_debug_pkg::CMD_WRITE_MEM && n > 5)
    begin
      for (i = 5; i < n && (i - 5) < count; i++)
      begin
        a = addr + 16'(i - 5);
        model[cur_pool][a[ADDR_W-1:0]] = frame_tx[i];
        known[cur_pool][a[ADDR_W-1:0]] = 1'b1;
      end
    end
    // value write frame is cmd, id lo, id hi, data lo, data hi
    if (frame_tx[0] == nes_debug_pkg::CMD_WRITE_VALUE && n >= 5 &&
        {frame_tx[2], frame_tx[1]} == nes_debug_pkg::VALUE_ID_MEM_POOL)
      cur_pool = frame_tx[3][0];
  endtask

  task automatic run_frame(input int n);
    int i;
    spi_cs_n = 1'b0;
    repeat (4) @(negedge clk);
    for (i = 0; i < n; i++)
    begin
      transfer_byte(frame_tx[i], frame_rx[i]);
      nes_gap();
    end
    spi_cs_n = 1'b1;
    repeat (8) @(negedge clk);
    update_model(n);
  endtask

  task automatic nes_read(input logic pool, input logic [15:0] addr, input logic [7:0] exp);
    if (pool == nes_debug_pkg::POOL_RAM)
    begin
      ram_nes_en      = 1'b1;
      ram_nes_address = addr;
    end
    else
    begin
      prg_nes_en      = 1'b1;
      prg_nes_address = addr;
    end
    @(negedge clk);
    ram_nes_en = 1'b0;
    prg_nes_en = 1'b0;
    if (pool == nes_debug_pkg::POOL_RAM)
      check_value("o_ram_nes_data", ram_nes_rdata, exp);
    else
      check_value("o_prg_nes_data", prg_nes_rdata, exp);
    repeat (2) @(negedge clk);
  endtask

  function automatic int count_frames();
    int p;
    int frames;
    p      = 0;
    frames = 0;
    while (p < TRACE_LEN && trace[p] !== 8'hff)
    begin
      case (trace[p])
        8'h01:
        begin
          frames++;
          p = p + 2 + trace[p+1];
        end
        8'h02: p = p + 3 + trace[p+2];
        8'h03: p = p + 5;
        8'h04: p = p + 2;
        default: p = TRACE_LEN;
      endcase
    end
    return frames;
  endfunction

  initial
  begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired before the trace finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial
  begin
    int pos;
    int j;
    clk             = 1'b0;
    rst             = 1'b1;
    spi_clk         = 1'b0;
    spi_cs_n        = 1'b1;
    spi_copi        = 1'b0;
    prg_nes_en      = 1'b0;
    prg_nes_address = 16'h0000;
    ram_nes_en      = 1'b0;
    ram_nes_rw      = nes_debug_pkg::RW_READ;
    ram_nes_address = 16'h0000;
    ram_nes_wdata   = 8'h00;
    cur_pool        = nes_debug_pkg::POOL_PRG;
    seed            = 32'h2e0f_d3cf;
    watchdog_cycles = 0;
    $readmemh("test/debug_trace.txt", trace);
    watchdog_cycles = count_frames() * 20 * 80 + 1000;

    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    check_value("o_nes_reset_n", nes_reset_n, 16'h0000);
    check_value("o_spi_cipo", spi_cipo, 16'h0000);

    pos = 0;
    while (trace[pos] !== 8'hff)
    begin
      case (trace[pos])
        8'h01:
        begin
          for (j = 0; j < trace[pos+1]; j++)
            frame_tx[j] = trace[pos+2+j];
          run_frame(trace[pos+1]);
          pos = pos + 2 + trace[pos+1];
        end
        8'h02:
        begin
          for (j = 0; j < trace[pos+2]; j++)
            check_value($sformatf("o_spi_cipo slot %0d", trace[pos+1] + j),
                        frame_rx[trace[pos+1] + j], trace[pos+3+j]);
          pos = pos + 3 + trace[pos+2];
        end
        8'h03:
        begin
          nes_read(trace[pos+1][0], {trace[pos+3], trace[pos+2]}, trace[pos+4]);
          pos = pos + 5;
        end
        8'h04:
        begin
          check_value("o_nes_reset_n", nes_reset_n, trace[pos+1]);
          pos = pos + 2;
        end
        default:
        begin
          $display("Trace record at position %0d is not a known record type", pos);
          $display("TEST FAILED");
          $fatal(1, "bad trace");
        end
      endcase
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule
